// ==== vlog.f ====
+incdir+.
silver_pkg.sv
silver_instr_in.sv
silver_decode.sv
silver_regfile.sv
silver_alu.sv
silver_execute.sv
silver_result_out.sv
silver_core.sv
tb_silver_core.sv

// ==== tb_silver_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "silver_config.svh"

module tb_silver_core;
   import silver_pkg::*;

   localparam int         TIMEOUT = 40;  // cycles per handshake wait
   localparam logic [5:0] NORM    = `SILVER_OPC_NORMAL;
   localparam logic [5:0] SHFT    = `SILVER_OPC_SHIFT;
   localparam word_t      R1_VAL  = 32'hd5923456;

   typedef struct packed {
      instr_u     instr;
      result_t    exp;
      logic [7:0] hold;  // cycles before out_ack
   } entry_t;

   logic    clk;
   logic    rst_n;
   logic    in_req;
   instr_u  in_instr;
   logic    in_ack;
   logic    out_req;
   logic    out_ack;
   result_t out_result;

   entry_t tbl [64];
   int     n_tbl;
   int     errors;
   int     checks;
   int     tests;
   integer seed = 32'haf8c7035;

   silver_core uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_req     (in_req),
      .in_instr   (in_instr),
      .in_ack     (in_ack),
      .out_req    (out_req),
      .out_ack    (out_ack),
      .out_result (out_result)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic instr_u reg_instr(input reg_addr_t rw, input logic a_imm,
         input reg_addr_t ra, input logic b_imm, input reg_addr_t rb,
         input logic [3:0] func, input logic [5:0] opc);
      instr_u i;
      i.r = {1'b0, rw, 1'b0, a_imm, ra, b_imm, rb, func, opc};
      return i;
   endfunction

   function automatic instr_u const_instr(input logic w_flag, input reg_addr_t rw,
         input logic negate, input logic [22:0] value);
      instr_u i;
      i.c = {w_flag, rw, 1'b1, negate, value};
      return i;
   endfunction

   function automatic result_t make_result(input reg_addr_t rd, input word_t value,
         input logic invalid);
      result_t r;
      r.rd      = rd;
      r.value   = value;
      r.invalid = invalid;
      return r;
   endfunction

   // reference shifter on b mod 32
   function automatic word_t shift_ref(input word_t a, input word_t b, input logic [1:0] kind);
      int    n;
      word_t r;
      n = b % 32;
      case (kind)
         2'd0: r = a << n;
         2'd1: r = a >> n;
         2'd2: begin
            r = a >> n;
            for (int i = 0; i < n; i++) begin
               r[31-i] = a[31];
            end
         end
         default: r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
      endcase
      return r;
   endfunction

   task automatic add_entry(input instr_u i, input reg_addr_t rd, input word_t value,
         input logic invalid, input int hold);
      tbl[n_tbl].instr = i;
      tbl[n_tbl].exp   = make_result(rd, value, invalid);
      tbl[n_tbl].hold  = hold[7:0];
      n_tbl++;
   endtask

   task automatic build_table();
      instr_u     i;
      word_t      rnd;
      logic [1:0] kind;
      add_entry(reg_instr(7, 0, 5, 0, 6, f_and, NORM), 7, 32'h0, 0, 0);
      add_entry(const_instr(1, 1, 0, 23'h123456), 1, 32'h00123456, 0, 0);
      add_entry(const_instr(1, 2, 1, 23'h5), 2, 32'hfffffffb, 0, 1);
      add_entry(const_instr(0, 1, 0, 23'h1ab), 1, R1_VAL, 0, 2);  // top 9 bits only
      add_entry(const_instr(1, 3, 1, 23'h1), 3, 32'hffffffff, 0, 0);
      add_entry(reg_instr(4, 0, 3, 1, 1, f_add, NORM), 4, 32'h0, 0, 0);
      add_entry(reg_instr(8, 0, 0, 0, 0, f_carry, NORM), 8, 32'h1, 0, 0);
      add_entry(reg_instr(9, 1, 2, 1, 3, f_add_carry, NORM), 9, 32'h6, 0, 0);
      add_entry(reg_instr(10, 0, 0, 0, 0, f_carry, NORM), 10, 32'h0, 0, 0);
      add_entry(const_instr(1, 11, 0, 23'h7fffff), 11, 32'h007fffff, 0, 0);
      add_entry(const_instr(0, 11, 0, 23'h0ff), 11, 32'h7fffffff, 0, 0);
      add_entry(reg_instr(12, 0, 11, 1, 1, f_add, NORM), 12, 32'h80000000, 0, 0);
      add_entry(reg_instr(13, 0, 0, 0, 0, f_overflow, NORM), 13, 32'h1, 0, 0);
      add_entry(reg_instr(14, 1, 5, 1, 3, f_sub, NORM), 14, 32'h2, 0, 0);
      add_entry(reg_instr(15, 0, 0, 0, 0, f_overflow, NORM), 15, 32'h0, 0, 0);
      add_entry(reg_instr(16, 0, 12, 1, 1, f_sub, NORM), 16, 32'h7fffffff, 0, 0);
      add_entry(reg_instr(17, 0, 0, 0, 0, f_overflow, NORM), 17, 32'h1, 0, 3);
      add_entry(reg_instr(18, 0, 11, 0, 0, f_inc, NORM), 18, 32'h80000000, 0, 0);
      add_entry(reg_instr(19, 1, 0, 0, 0, f_dec, NORM), 19, 32'hffffffff, 0, 0);
      add_entry(reg_instr(20, 0, 2, 1, 7, f_mul, NORM), 20, 32'hffffffdd, 0, 0);
      add_entry(reg_instr(21, 0, 2, 1, 7, f_mul_hu, NORM), 21, 32'h6, 0, 0);
      add_entry(reg_instr(22, 0, 1, 0, 11, f_and, NORM), 22, 32'h55923456, 0, 0);
      add_entry(reg_instr(23, 0, 2, 1, 4, f_or, NORM), 23, 32'hffffffff, 0, 0);
      add_entry(reg_instr(24, 0, 1, 0, 3, f_xor, NORM), 24, 32'h2a6dcba9, 0, 0);
      add_entry(reg_instr(25, 0, 4, 1, 0, f_equal, NORM), 25, 32'h1, 0, 0);
      add_entry(reg_instr(26, 0, 2, 1, 3, f_less, NORM), 26, 32'h1, 0, 0);
      add_entry(reg_instr(27, 0, 2, 1, 3, f_lower, NORM), 27, 32'h0, 0, 0);
      add_entry(reg_instr(28, 0, 0, 1, 6'h39, f_snd, NORM), 28, 32'hfffffff9, 0, 0);  // imm -7
      add_entry(reg_instr(29, 0, 1, 1, 4, 4'd0, SHFT), 29, 32'h59234560, 0, 0);
      add_entry(reg_instr(30, 0, 2, 1, 4, 4'd1, SHFT), 30, 32'h0fffffff, 0, 0);
      add_entry(reg_instr(31, 0, 1, 1, 4, 4'd2, SHFT), 31, 32'hfd592345, 0, 0);
      add_entry(reg_instr(32, 0, 1, 1, 8, 4'd3, SHFT), 32, 32'h56d59234, 0, 0);
      add_entry(reg_instr(33, 0, 1, 1, 0, 4'd3, SHFT), 33, R1_VAL, 0, 0);
      add_entry(const_instr(1, 34, 0, 23'd36), 34, 32'd36, 0, 0);
      add_entry(reg_instr(35, 0, 1, 0, 34, 4'd3, SHFT), 35, 32'h6d592345, 0, 0);
      // random amounts through r40 often exceed 31
      for (int k = 0; k < 3; k++) begin
         rnd  = $random(seed);
         kind = rnd[31:30];
         add_entry(const_instr(1, 40, 0, rnd[22:0]), 40, word_t'(rnd[22:0]), 0, 0);
         add_entry(reg_instr(reg_addr_t'(41 + k), 0, 1, 0, 40, {2'b00, kind}, SHFT),
                   reg_addr_t'(41 + k), shift_ref(R1_VAL, word_t'(rnd[22:0]), kind), 0, k);
      end
      add_entry(reg_instr(1, 0, 3, 0, 4, f_add, 6'd9), 1, 32'h0, 1, 0);
      i = reg_instr(1, 0, 3, 0, 4, f_add, NORM);
      i.r.w_imm = 1'b1;
      add_entry(i, 1, 32'h0, 1, 0);
      add_entry(const_instr(0, 1, 0, 23'h200), 1, 32'h0, 1, 0);
      add_entry(reg_instr(37, 0, 0, 0, 1, f_snd, NORM), 37, R1_VAL, 0, 0);  // r1 untouched
   endtask

   task automatic check_result(input result_t got, input result_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s rd/value/invalid got %0d/%h/%b, expected %0d/%h/%b",
                  $time, what, got.rd, got.value, got.invalid,
                  exp.rd, exp.value, exp.invalid);
      end
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic stall(input string what);
      $display("timeout: the %s handshake stalled", what);
      $display("TESTS FAILED");
      $finish;
   endtask

   task automatic start_send(input instr_u i);
      @(negedge clk);
      in_instr = i;
      in_req   = 1'b1;
   endtask

   task automatic finish_send();
      int n;
      n = 0;
      while (!in_ack && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!in_ack) stall("input (in_ack never rose)");
      in_req = 1'b0;
      n = 0;
      while (in_ack && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (in_ack) stall("input (in_ack never fell)");
   endtask

   task automatic send_instr(input instr_u i);
      start_send(i);
      finish_send();
   endtask

   task automatic wait_out_req();
      int n;
      n = 0;
      while (!out_req && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!out_req) stall("output (out_req never rose)");
   endtask

   task automatic receive_result(input result_t exp, input int hold);
      int n;
      wait_out_req();
      check_result(out_result, exp, "out_result");
      repeat (hold) @(negedge clk);
      out_ack = 1'b1;
      n = 0;
      while (out_req && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (out_req) stall("output (out_req never fell)");
      out_ack = 1'b0;
   endtask

   // A holds the output while B fills the input buffer and C waits unacked
   task automatic backpressure_test();
      int err0;
      int acks;
      err0 = errors;
      acks = 0;
      send_instr(const_instr(1, 50, 0, 23'h55));
      wait_out_req();
      send_instr(const_instr(1, 51, 1, 23'h66));
      start_send(reg_instr(52, 0, 50, 0, 51, f_add, NORM));
      repeat (6) begin
         @(negedge clk);
         if (in_ack) acks++;
      end
      check_word(word_t'(acks), '0, "in_ack cycles under back-pressure");
      receive_result(make_result(50, 32'h00000055, 0), 3);
      receive_result(make_result(51, 32'hffffff9a, 0), 0);
      finish_send();
      receive_result(make_result(52, 32'hffffffef, 0), 0);
      tests++;
      $display("test back-pressure %s", (errors == err0) ? "ok" : "failed");
   endtask

   initial begin
      int err0;
      rst_n    = 1'b0;
      in_req   = 1'b0;
      in_instr = '0;
      out_ack  = 1'b0;
      n_tbl    = 0;
      errors   = 0;
      checks   = 0;
      tests    = 0;
      build_table();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_word(word_t'(in_ack), '0, "in_ack after reset");
      check_word(word_t'(out_req), '0, "out_req after reset");
      for (int k = 0; k < n_tbl; k++) begin
         err0 = errors;
         send_instr(tbl[k].instr);
         receive_result(tbl[k].exp, tbl[k].hold);
         tests++;
         $display("test %0d %s", k, (errors == err0) ? "ok" : "failed");
      end
      backpressure_test();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== silver_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module silver_core (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_req,
   input  silver_pkg::instr_u  in_instr,
   output logic                in_ack,
   output logic                out_req,
   input  logic                out_ack,
   output silver_pkg::result_t out_result
);
   import silver_pkg::*;

   instr_u  instr;
   result_t result;
   logic    full;
   logic    free;
   logic    take;
   logic    load;

   silver_instr_in u_instr_in (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_req   (in_req),
      .in_instr (in_instr),
      .in_ack   (in_ack),
      .instr    (instr),
      .full     (full),
      .take     (take)
   );

   silver_execute u_execute (
      .clk    (clk),
      .rst_n  (rst_n),
      .instr  (instr),
      .full   (full),
      .free   (free),
      .take   (take),
      .load   (load),
      .result (result)
   );

   silver_result_out u_result_out (
      .clk        (clk),
      .rst_n      (rst_n),
      .load       (load),
      .result_in  (result),
      .free       (free),
      .out_req    (out_req),
      .out_ack    (out_ack),
      .out_result (out_result)
   );

endmodule

`default_nettype wire

// ==== silver_result_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module silver_result_out (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load,
   input  silver_pkg::result_t result_in,
   output logic                free,
   output logic                out_req,
   input  logic                out_ack,
   output silver_pkg::result_t out_result
);
   import silver_pkg::*;

   result_t res_q;
   logic    req_q;
   logic    wait_low;  // ack seen, waiting for it to drop

   always_ff @(posedge clk) begin
      if (load) begin
         res_q <= result_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_q    <= 1'b0;
         wait_low <= 1'b0;
      end else if (load) begin
         req_q <= 1'b1;
      end else if (req_q && out_ack) begin
         req_q    <= 1'b0;
         wait_low <= 1'b1;
      end else if (wait_low && !out_ack) begin
         wait_low <= 1'b0;
      end
   end

   // load only arrives while free, so it never overlaps a handshake
   assign free       = !(req_q || wait_low);
   assign out_req    = req_q;
   assign out_result = res_q;

endmodule

`default_nettype wire

// ==== silver_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "silver_config.svh"

module silver_execute (
   input  logic                clk,
   input  logic                rst_n,
   input  silver_pkg::instr_u  instr,
   input  logic                full,
   input  logic                free,
   output logic                take,
   output logic                load,
   output silver_pkg::result_t result
);
   import silver_pkg::*;

   localparam int W    = `SILVER_WORD_W;
   localparam int SH_W = $clog2(`SILVER_WORD_W);

   decoded_t       dec;
   word_t          a_reg;
   word_t          b_reg;
   word_t          w_reg;
   word_t          a_val;
   word_t          b_val;
   word_t          alu_res;
   word_t          shift_res;
   word_t          value;
   logic [SH_W-1:0] sh;
   logic [2*W-1:0] rot;
   logic           advance;
   logic           valid;

   silver_decode u_decode (
      .instr (instr),
      .dec   (dec)
   );

   silver_regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .ra      (dec.ra),
      .rb      (dec.rb),
      .rw      (dec.rw),
      .a_data  (a_reg),
      .b_data  (b_reg),
      .w_data  (w_reg),
      .wr_en   (advance && valid),
      .wr_addr (dec.rw),
      .wr_data (value)
   );

   silver_alu u_alu (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (advance && (dec.kind == op_normal)),
      .func   (dec.func),
      .a      (a_val),
      .b      (b_val),
      .res    (alu_res)
   );

   // one instruction per cycle when there is one and room for its result
   assign advance = full && free;
   assign take    = advance;
   assign load    = advance;
   assign valid   = (dec.kind != op_invalid);

   assign a_val = dec.a_imm ? dec.a_ext : a_reg;
   assign b_val = dec.b_imm ? dec.b_ext : b_reg;
   assign sh    = b_val[SH_W-1:0];  // b mod 32
   assign rot   = {a_val, a_val} >> sh;

   always_comb begin
      case (dec.func[1:0])
         2'd0:    shift_res = a_val << sh;
         2'd1:    shift_res = a_val >> sh;
         2'd2:    shift_res = word_t'($signed(a_val) >>> sh);
         default: shift_res = rot[W-1:0];  // rotate right
      endcase
   end

   always_comb begin
      case (dec.kind)
         op_normal:     value = alu_res;
         op_shift:      value = shift_res;
         op_load_const: value = dec.const_val;
         op_load_upper: value = {dec.const_val[8:0], w_reg[22:0]};
         default:       value = '0;
      endcase
   end

   assign result.rd      = dec.rw;
   assign result.value   = value;
   assign result.invalid = !valid;

endmodule

`default_nettype wire

// ==== silver_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "silver_config.svh"

module silver_alu (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  silver_pkg::alu_func_t func,
   input  silver_pkg::word_t     a,
   input  silver_pkg::word_t     b,
   output silver_pkg::word_t     res
);
   import silver_pkg::*;

   localparam int W = `SILVER_WORD_W;

   logic           carry_q;
   logic           overflow_q;
   logic           cin;
   logic [W:0]     sum;
   word_t          diff;
   logic [2*W-1:0] prod;
   logic           add_ovf;
   logic           sub_ovf;

   assign cin  = (func == f_add_carry) && carry_q;
   assign sum  = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
   assign diff = a - b;
   assign prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};

   // signed overflow from the operand and result sign bits
   assign add_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
   assign sub_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

   always_comb begin
      case (func)
         f_add, f_add_carry: res = sum[W-1:0];
         f_sub:              res = diff;
         f_carry:            res = word_t'(carry_q);
         f_overflow:         res = word_t'(overflow_q);
         f_inc:              res = a + word_t'(1);
         f_dec:              res = a - word_t'(1);
         f_mul:              res = prod[W-1:0];
         f_mul_hu:           res = prod[2*W-1:W];  // high half, unsigned
         f_and:              res = a & b;
         f_or:               res = a | b;
         f_xor:              res = a ^ b;
         f_equal:            res = word_t'(a == b);
         f_less:             res = word_t'($signed(a) < $signed(b));
         f_lower:            res = word_t'(a < b);
         default:            res = b;              // f_snd
      endcase
   end

   // flags persist from one instruction to the next
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         carry_q    <= 1'b0;
         overflow_q <= 1'b0;
      end else if (enable) begin
         case (func)
            f_add: begin
               carry_q    <= sum[W];
               overflow_q <= add_ovf;
            end
            f_add_carry: carry_q    <= sum[W];
            f_sub:       overflow_q <= sub_ovf;
            default:     ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== silver_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "silver_config.svh"

module silver_regfile (
   input  logic                  clk,
   input  logic                  rst_n,
   input  silver_pkg::reg_addr_t ra,
   input  silver_pkg::reg_addr_t rb,
   input  silver_pkg::reg_addr_t rw,
   output silver_pkg::word_t     a_data,
   output silver_pkg::word_t     b_data,
   output silver_pkg::word_t     w_data,
   input  logic                  wr_en,
   input  silver_pkg::reg_addr_t wr_addr,
   input  silver_pkg::word_t     wr_data
);
   import silver_pkg::*;

   word_t regs [`SILVER_REG_COUNT];

   assign a_data = regs[ra];
   assign b_data = regs[rb];
   assign w_data = regs[rw];  // old value for load upper

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `SILVER_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== silver_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "silver_config.svh"

module silver_decode (
   input  silver_pkg::instr_u   instr,
   output silver_pkg::decoded_t dec
);
   import silver_pkg::*;

   localparam int EXT_W = `SILVER_WORD_W - `SILVER_REG_AW;

   logic [5:0] opc_eff;
   logic       upper_ok;

   // bits 23..9 clear, i.e. negate and the upper value bits
   assign upper_ok = !instr.c.negate && (instr.c.value[22:9] == '0);

   // one opcode for both views, 3f marks anything not kept
   always_comb begin
      if (instr.c.is_const) begin
         if (instr.c.w_flag) begin
            opc_eff = `SILVER_OPC_LOADCONST;
         end else if (upper_ok) begin
            opc_eff = `SILVER_OPC_LOADUPPER;
         end else begin
            opc_eff = 6'h3f;
         end
      end else if (!instr.r.w_imm && (instr.r.opc == `SILVER_OPC_NORMAL ||
                                      instr.r.opc == `SILVER_OPC_SHIFT)) begin
         opc_eff = instr.r.opc;
      end else begin
         opc_eff = 6'h3f;
      end
   end

   always_comb begin
      dec.func  = instr.r.func;
      dec.ra    = instr.r.ra;
      dec.rb    = instr.r.rb;
      dec.rw    = instr.r.rw;  // same place in the constant view
      dec.a_imm = instr.r.a_imm;
      dec.b_imm = instr.r.b_imm;
      dec.a_ext = {{EXT_W{instr.r.ra[`SILVER_REG_AW-1]}}, instr.r.ra};
      dec.b_ext = {{EXT_W{instr.r.rb[`SILVER_REG_AW-1]}}, instr.r.rb};
      case (opc_eff)
         `SILVER_OPC_NORMAL: begin
            dec.kind      = op_normal;
            dec.const_val = '0;
         end
         `SILVER_OPC_SHIFT: begin
            dec.kind      = op_shift;
            dec.const_val = '0;
         end
         `SILVER_OPC_LOADCONST: begin
            dec.kind      = op_load_const;
            dec.const_val = instr.c.negate ? word_t'(0) - word_t'(instr.c.value)
                                           : word_t'(instr.c.value);
         end
         `SILVER_OPC_LOADUPPER: begin
            dec.kind      = op_load_upper;
            dec.const_val = word_t'(instr.c.value[8:0]);
         end
         default: begin
            dec.kind      = op_invalid;
            dec.const_val = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== silver_instr_in.sv ====
`timescale 1ns/1ps
`default_nettype none

module silver_instr_in (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_req,
   input  silver_pkg::instr_u in_instr,
   output logic               in_ack,
   output silver_pkg::instr_u instr,
   output logic               full,
   input  logic               take
);
   import silver_pkg::*;

   instr_u instr_q;
   logic   full_q;
   logic   ack_q;
   logic   capture;

   // new word only into an empty buffer, and only once per handshake
   assign capture = in_req && !full_q && !ack_q;

   always_ff @(posedge clk) begin
      if (capture) begin
         instr_q <= in_instr;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full_q <= 1'b0;
         ack_q  <= 1'b0;
      end else if (capture) begin
         full_q <= 1'b1;
         ack_q  <= 1'b1;
      end else begin
         if (take) begin
            full_q <= 1'b0;
         end
         if (ack_q && !in_req) begin
            ack_q <= 1'b0;  // sender has let go of req
         end
      end
   end

   assign in_ack = ack_q;
   assign instr  = instr_q;
   assign full   = full_q;

endmodule

`default_nettype wire

// ==== silver_pkg.sv ====
`default_nettype none

`include "silver_config.svh"

package silver_pkg;

   typedef logic [`SILVER_WORD_W-1:0] word_t;
   typedef logic [`SILVER_REG_AW-1:0] reg_addr_t;

   // order matches the func field encoding
   typedef enum logic [3:0] {
      f_add, f_add_carry, f_sub, f_carry,
      f_overflow, f_inc, f_dec, f_mul,
      f_mul_hu, f_and, f_or, f_xor,
      f_equal, f_less, f_lower, f_snd
   } alu_func_t;

   typedef enum logic [2:0] {
      op_normal,
      op_shift,
      op_load_const,
      op_load_upper,
      op_invalid
   } op_kind_t;

   typedef struct packed {
      logic       w_imm;
      reg_addr_t  rw;
      logic       is_const;
      logic       a_imm;
      reg_addr_t  ra;
      logic       b_imm;
      reg_addr_t  rb;
      alu_func_t  func;
      logic [5:0] opc;
   } instr_reg_t;

   typedef struct packed {
      logic        w_flag;
      reg_addr_t   rw;
      logic        is_const;  // same bit as in the register view
      logic        negate;
      logic [22:0] value;
   } instr_const_t;

   typedef union packed {
      instr_reg_t   r;
      instr_const_t c;
   } instr_u;

   typedef struct packed {
      op_kind_t  kind;
      alu_func_t func;
      reg_addr_t ra;
      reg_addr_t rb;
      reg_addr_t rw;
      logic      a_imm;
      logic      b_imm;
      word_t     a_ext;      // sign-extended ra field
      word_t     b_ext;      // sign-extended rb field
      word_t     const_val;
   } decoded_t;

   typedef struct packed {
      reg_addr_t rd;
      word_t     value;
      logic      invalid;
   } result_t;

endpackage

`default_nettype wire

// ==== silver_config.svh ====
`ifndef SILVER_CONFIG_SVH
`define SILVER_CONFIG_SVH

// datapath and register file sizes
`define SILVER_WORD_W      32
`define SILVER_REG_AW      6
`define SILVER_REG_COUNT   64

// opcodes kept by the execute core
`define SILVER_OPC_NORMAL     6'd0
`define SILVER_OPC_SHIFT      6'd1
`define SILVER_OPC_LOADCONST  6'd13
`define SILVER_OPC_LOADUPPER  6'd14

`endif
